/* hdl/pkt_comm_config.svh */
`ifndef PKT_COMM_CONFIG_SVH
`define PKT_COMM_CONFIG_SVH

// ********************
// protocol constants
// ********************

// the only input packet version accepted
`define PKT_COMM_VERSION 2

// input packet type: list of candidate words
`define PKT_TYPE_WORD_LIST 1

// type byte placed in the first output word
`define OUTPKT_TYPE_CMP_RESULT 8'h81

// ********************
// sizes
// ********************

// longest candidate word, in bytes
`define WORD_MAX_LEN 8

// word records held between word_list and outpkt
`define WORD_LIST_DEPTH 4

// input header bytes, not counting its checksum
`define INPKT_HEADER_LEN 10

// 16-bit words in each output packet
`define OUTPKT_LEN 10

`endif

/* hdl/pkt_comm_pkg.sv */
`include "pkt_comm_config.svh"

package pkt_comm_pkg;

	// ********************
	// input packet header
	// ********************

	// raw view is indexed by arrival order, byte 0 in the low bits
	// field view lists members from the high end, so last byte first
	typedef union packed {
		logic [`INPKT_HEADER_LEN-1:0][7:0] raw;
		struct packed {
			logic [15:0] pkt_id;
			logic [7:0] rsvd2;
			// little endian, bytes 4..6
			logic [23:0] len;
			logic [7:0] rsvd1;
			logic [7:0] rsvd0;
			logic [7:0] pkt_type;
			logic [7:0] version;
		} f;
	} inpkt_header_t;

	// one data byte from the parser, strobed by valid
	typedef struct packed {
		logic [7:0] dbyte;
		logic [15:0] pkt_id;
		logic valid;
		// final data byte of the packet
		logic last;
	} inpkt_data_t;

	// one stored candidate word
	typedef struct packed {
		logic [15:0] pkt_id;
		logic [15:0] word_id;
		logic [7:0] word_len;
		// byte 0 first, bytes past word_len are zero
		logic [0:`WORD_MAX_LEN-1][7:0] chars;
	} word_rec_t;

	// sticky error flags, msb first
	typedef struct packed {
		logic err_cmp_config;
		logic err_word_gen;
		logic err_word_list;
		logic err_count;
		logic err_version;
		logic err_type;
		logic err_len;
		logic err_checksum;
	} pkt_comm_status_t;

endpackage

/* hdl/inpkt_header.sv */
`timescale 1ns/1ns
`include "pkt_comm_config.svh"

module inpkt_header import pkt_comm_pkg::*; (
	input logic pkt_comm_clk,
	input logic rst,
	input logic [7:0] din,
	input logic empty,
	output logic rd_en,
	input logic data_full,
	input logic word_list_err,
	output inpkt_data_t data,
	output logic [3:0] err
);

	// header byte positions that get checked on arrival
	localparam int HB_VERSION = 0;
	localparam int HB_TYPE = 1;
	localparam int HB_LEN_LAST = 6;

	typedef enum logic [1:0] {
		ST_HDR,
		ST_HDR_CSUM,
		ST_DATA,
		ST_DATA_CSUM
	} state_t;

	state_t state;
	// byte index inside header or checksum
	logic [3:0] cnt;
	inpkt_header_t hdr;
	// running sum of covered bytes
	logic [31:0] sum;
	// first three checksum bytes received
	logic [23:0] csum_lo;
	logic [15:0] data_left;
	logic err_csum;
	logic err_len;
	logic err_type;
	logic err_version;
	logic csum_ok;
	logic d_valid;
	logic d_last;
	logic [7:0] d_byte;

	assign err = {err_version, err_type, err_len, err_csum};

	// header and checksum bytes ignore data_full
	// any error, here or downstream, stops reading until rst
	assign rd_en = ~empty & ~(|err) & ~word_list_err
		& (state != ST_DATA | ~data_full);

	// valid only while the 4th checksum byte is on din
	assign csum_ok = {din, csum_lo} == ~sum;

	// ********************
	// phase FSM and checks
	// ********************
	always_ff @(posedge pkt_comm_clk) begin
		if (rst) begin
			state <= ST_HDR;
			cnt <= '0;
			sum <= '0;
			err_csum <= 1'b0;
			err_len <= 1'b0;
			err_type <= 1'b0;
			err_version <= 1'b0;
		end else if (rd_en) begin
			case (state)
			ST_HDR: begin
				sum <= sum + din;
				if (cnt == HB_VERSION && din != `PKT_COMM_VERSION)
					err_version <= 1'b1;
				if (cnt == HB_TYPE && din != `PKT_TYPE_WORD_LIST)
					err_type <= 1'b1;
				// zero length, or anything past 16 bits
				if (cnt == HB_LEN_LAST && (din != 8'd0 || hdr.f.len[15:0] == 16'd0))
					err_len <= 1'b1;
				if (cnt == `INPKT_HEADER_LEN - 1) begin
					state <= ST_HDR_CSUM;
					cnt <= '0;
				end else
					cnt <= cnt + 1'b1;
			end
			ST_HDR_CSUM: begin
				if (cnt == 3) begin
					cnt <= '0;
					sum <= '0;
					// bad header: stay here, rd_en is already gone
					if (csum_ok)
						state <= ST_DATA;
					else
						err_csum <= 1'b1;
				end else
					cnt <= cnt + 1'b1;
			end
			ST_DATA: begin
				sum <= sum + din;
				if (data_left == 16'd1) begin
					state <= ST_DATA_CSUM;
					cnt <= '0;
				end
			end
			ST_DATA_CSUM: begin
				if (cnt == 3) begin
					cnt <= '0;
					sum <= '0;
					state <= ST_HDR;
					if (!csum_ok)
						err_csum <= 1'b1;
				end else
					cnt <= cnt + 1'b1;
			end
			endcase
		end
	end

	// ********************
	// byte capture
	// ********************
	always_ff @(posedge pkt_comm_clk) begin
		if (rd_en) begin
			case (state)
			ST_HDR:
				hdr.raw[cnt] <= din;
			ST_HDR_CSUM: begin
				if (cnt < 3)
					csum_lo[8*cnt[1:0] +: 8] <= din;
				// length already checked to fit 16 bits
				data_left <= hdr.f.len[15:0];
			end
			ST_DATA: begin
				d_byte <= din;
				d_last <= data_left == 16'd1;
				data_left <= data_left - 1'b1;
			end
			ST_DATA_CSUM: begin
				if (cnt < 3)
					csum_lo[8*cnt[1:0] +: 8] <= din;
			end
			endcase
		end
	end

	// strobe one cycle after the edge that read the byte
	always_ff @(posedge pkt_comm_clk) begin
		if (rst)
			d_valid <= 1'b0;
		else
			d_valid <= rd_en & (state == ST_DATA);
	end

	// pkt_id holds still until the next header arrives
	assign data = '{dbyte: d_byte, pkt_id: hdr.f.pkt_id, valid: d_valid, last: d_last};

endmodule

/* hdl/word_list.sv */
`timescale 1ns/1ns
`include "pkt_comm_config.svh"

module word_list import pkt_comm_pkg::*; (
	input logic pkt_comm_clk,
	input logic rst,
	input inpkt_data_t data,
	output logic full,
	output word_rec_t rec,
	output logic rec_ready,
	input logic rec_take,
	output logic err
);

	localparam int DEPTH = `WORD_LIST_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int IDX_W = $clog2(`WORD_MAX_LEN);

	// word being assembled
	logic [0:`WORD_MAX_LEN-1][7:0] chars;
	logic [7:0] len;
	logic [15:0] word_id;
	word_rec_t new_rec;

	// record queue
	word_rec_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	logic is_term;
	logic push;
	logic pop;
	logic bad;

	assign is_term = data.valid & (data.dbyte == 8'd0);
	assign push = is_term & (len != 8'd0) & ~err;
	assign pop = rec_take & rec_ready;

	// too long, empty word, or packet ends mid-word
	assign bad = data.valid & ~err & (
		(is_term & len == 8'd0)
		| (~is_term & len == `WORD_MAX_LEN)
		| (data.last & ~is_term));

	// zero the bytes past the end so records compare cleanly
	always_comb begin
		new_rec.pkt_id = data.pkt_id;
		new_rec.word_id = word_id;
		new_rec.word_len = len;
		for (int i = 0; i < `WORD_MAX_LEN; i++)
			new_rec.chars[i] = (i < len) ? chars[i] : 8'd0;
	end

	// ********************
	// word assembly
	// ********************
	always_ff @(posedge pkt_comm_clk) begin
		if (rst) begin
			len <= '0;
			word_id <= '0;
			err <= 1'b0;
		end else if (data.valid & ~err) begin
			if (bad)
				err <= 1'b1;
			else if (is_term) begin
				len <= '0;
				word_id <= word_id + 1'b1;
			end else
				len <= len + 1'b1;
			// word_id restarts with every packet
			if (data.last)
				word_id <= '0;
		end
	end

	always_ff @(posedge pkt_comm_clk) begin
		if (data.valid & ~is_term & len < `WORD_MAX_LEN)
			chars[len[IDX_W-1:0]] <= data.dbyte;
	end

	// ********************
	// record queue
	// ********************
	always_ff @(posedge pkt_comm_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge pkt_comm_clk) begin
		if (push)
			mem[wr_ptr] <= new_rec;
	end

	// a terminator in flight already owns the last slot
	assign full = (count == DEPTH) | ((count == DEPTH - 1) & push);
	assign rec_ready = count != '0;
	assign rec = mem[rd_ptr];

endmodule

/* hdl/outpkt.sv */
`timescale 1ns/1ns
`include "pkt_comm_config.svh"

module outpkt import pkt_comm_pkg::*; (
	input logic pkt_comm_clk,
	input logic rst,
	input word_rec_t rec,
	input logic rec_ready,
	output logic rec_take,
	output logic [15:0] dout,
	output logic wr_en,
	input logic full
);

	localparam int LAST = `OUTPKT_LEN - 1;
	// first of the two checksum words
	localparam int CSUM_POS = `OUTPKT_LEN - 2;
	localparam logic [7:0] VERSION = `PKT_COMM_VERSION;

	// record being sent
	word_rec_t cur;
	logic busy;
	logic [3:0] cnt;
	// sum of words 0..CSUM_POS-1
	logic [31:0] sum;
	logic last_word;

	assign wr_en = busy & ~full;
	assign last_word = wr_en & (cnt == LAST);

	// next record can start on the edge that writes the last word
	assign rec_take = rec_ready & (~busy | last_word);

	// ********************
	// word select
	// ********************
	always_comb begin
		case (cnt)
		4'd0: dout = {`OUTPKT_TYPE_CMP_RESULT, VERSION};
		4'd1: dout = cur.pkt_id;
		4'd2: dout = cur.word_id;
		4'd3: dout = {8'd0, cur.word_len};
		// even byte goes low
		4'd4, 4'd5, 4'd6, 4'd7:
			dout = {cur.chars[{cnt[1:0], 1'b1}], cur.chars[{cnt[1:0], 1'b0}]};
		4'd8: dout = ~sum[15:0];
		default: dout = ~sum[31:16];
		endcase
	end

	// ********************
	// sequencing
	// ********************
	always_ff @(posedge pkt_comm_clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			sum <= '0;
		end else if (rec_take) begin
			busy <= 1'b1;
			cnt <= '0;
			sum <= '0;
		end else if (wr_en) begin
			// full only stalls, cnt holds
			if (cnt == LAST)
				busy <= 1'b0;
			cnt <= cnt + 1'b1;
			if (cnt < CSUM_POS)
				sum <= sum + dout;
		end
	end

	always_ff @(posedge pkt_comm_clk) begin
		if (rec_take)
			cur <= rec;
	end

endmodule

/* hdl/pkt_comm.sv */
`timescale 1ns/1ns

module pkt_comm import pkt_comm_pkg::*; (
	input logic pkt_comm_clk,
	input logic rst,
	// input byte FIFO
	input logic [7:0] din,
	input logic empty,
	output logic rd_en,
	// output word FIFO
	output logic [15:0] dout,
	output logic wr_en,
	input logic full,
	output pkt_comm_status_t pkt_comm_status
);

	inpkt_data_t data;
	logic data_full;
	// checksum, length, type, version from lsb
	logic [3:0] hdr_err;
	logic word_list_err;
	word_rec_t rec;
	logic rec_ready;
	logic rec_take;

	// ********************
	// input parser
	// ********************
	inpkt_header inpkt_header (
		.pkt_comm_clk(pkt_comm_clk),
		.rst(rst),
		.din(din),
		.empty(empty),
		.rd_en(rd_en),
		.data_full(data_full),
		.word_list_err(word_list_err),
		.data(data),
		.err(hdr_err)
	);

	// ********************
	// word split and queue
	// ********************
	word_list word_list (
		.pkt_comm_clk(pkt_comm_clk),
		.rst(rst),
		.data(data),
		.full(data_full),
		.rec(rec),
		.rec_ready(rec_ready),
		.rec_take(rec_take),
		.err(word_list_err)
	);

	// ********************
	// output packets
	// ********************
	outpkt outpkt (
		.pkt_comm_clk(pkt_comm_clk),
		.rst(rst),
		.rec(rec),
		.rec_ready(rec_ready),
		.rec_take(rec_take),
		.dout(dout),
		.wr_en(wr_en),
		.full(full)
	);

	// count, word gen and cmp config sources are not present
	assign pkt_comm_status = '{
		err_cmp_config: 1'b0,
		err_word_gen: 1'b0,
		err_word_list: word_list_err,
		err_count: 1'b0,
		err_version: hdr_err[3],
		err_type: hdr_err[2],
		err_len: hdr_err[1],
		err_checksum: hdr_err[0]
	};

endmodule

/* tests/pkt_comm_properties.sv */
`timescale 1ns/1ns

module pkt_comm_properties import pkt_comm_pkg::*; (
	input logic pkt_comm_clk,
	input logic rst,
	input logic empty,
	input logic rd_en,
	input logic full,
	input logic wr_en,
	input pkt_comm_status_t pkt_comm_status
);

	// bumped by every failing assertion, read by the testbench at the end
	int unsigned assert_fails = 0;

	// ********************
	// FIFO handshakes
	// ********************
	rd_while_empty: assert property (@(posedge pkt_comm_clk) disable iff (rst)
		!(rd_en && empty))
	else begin
		$error("rd_en high while the input FIFO is empty");
		assert_fails++;
	end

	wr_while_full: assert property (@(posedge pkt_comm_clk) disable iff (rst)
		!(wr_en && full))
	else begin
		$error("wr_en high while the output FIFO is full");
		assert_fails++;
	end

	// ********************
	// sticky status
	// ********************
	// a bit that was set may only clear through rst
	status_sticky: assert property (@(posedge pkt_comm_clk) disable iff (rst)
		($past(pkt_comm_status) & ~pkt_comm_status) == 8'd0)
	else begin
		$error("a status bit fell without rst");
		assert_fails++;
	end

	// any error freezes the input side
	no_read_after_err: assert property (@(posedge pkt_comm_clk) disable iff (rst)
		(|pkt_comm_status) |-> !rd_en)
	else begin
		$error("rd_en high with an error bit set");
		assert_fails++;
	end

endmodule

bind pkt_comm pkt_comm_properties props (
	.pkt_comm_clk(pkt_comm_clk),
	.rst(rst),
	.empty(empty),
	.rd_en(rd_en),
	.full(full),
	.wr_en(wr_en),
	.pkt_comm_status(pkt_comm_status)
);

/* tests/pkt_comm_tb.sv */
`timescale 1ns/1ns
`include "pkt_comm_config.svh"

module pkt_comm_tb import pkt_comm_pkg::*; ();

	localparam logic [7:0] VERSION = `PKT_COMM_VERSION;
	// cycles allowed for stray output after a scenario looks done
	localparam int SETTLE = 64;

	logic clk;
	logic rst;
	logic [7:0] din;
	logic empty;
	logic rd_en;
	logic [15:0] dout;
	logic wr_en;
	logic full;
	pkt_comm_status_t status;

	// input FIFO contents, output words seen, model output
	logic [7:0] in_q[$];
	logic [15:0] out_q[$];
	logic [15:0] exp_q[$];
	// data bytes of the packet being built
	logic [7:0] pkt_data[$];
	logic [15:0] cur_pkt_id;
	logic [15:0] word_idx;

	logic [31:0] lfsr = 32'h431b795c;
	// gap chance out of 8 per cycle
	int empty_rate;
	int full_rate;
	int cycles;
	int cycle_limit;

	pkt_comm dut (
		.pkt_comm_clk(clk),
		.rst(rst),
		.din(din),
		.empty(empty),
		.rd_en(rd_en),
		.dout(dout),
		.wr_en(wr_en),
		.full(full),
		.pkt_comm_status(status)
	);

	always #2 clk = ~clk;

	// ********************
	// helpers
	// ********************
	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("** Error @%0t: %s: got %h, expected %h",
				$time, what, got, exp));
	endtask

	// ********************
	// FIFO models
	// ********************
	// input side pops on rd_en and output side collects on wr_en
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			abort_run($sformatf("timeout: scenario not done after %0d cycles", cycles));
		if (dut.props.assert_fails != 0)
			abort_run("a bound assertion on the DUT ports failed");
		if (rd_en === 1'b1) begin
			if (in_q.size() == 0)
				abort_run("the DUT read a byte that the input FIFO did not hold");
			void'(in_q.pop_front());
		end
		if (wr_en === 1'b1)
			out_q.push_back(dout);
		// first word fall through shows the head byte on din
		if (in_q.size() != 0 && rand_bits(3) >= empty_rate) begin
			din <= in_q[0];
			empty <= 1'b0;
		end else
			empty <= 1'b1;
		full <= rand_bits(3) < full_rate;
	end

	// ********************
	// packet model
	// ********************
	task automatic start_packet(input logic [15:0] id);
		cur_pkt_id = id;
		word_idx = '0;
		pkt_data.delete();
	endtask

	// random word plus terminator and its expected output packet if emit
	task automatic add_word(input int len, input bit emit);
		logic [7:0] chars [16];
		logic [15:0] w [`OUTPKT_LEN];
		logic [31:0] sum;
		foreach (chars[i])
			chars[i] = 8'd0;
		for (int i = 0; i < len; i++) begin
			// zero would end the word early
			do begin
				chars[i] = 8'(rand_bits(8));
			end while (chars[i] == 8'd0);
			pkt_data.push_back(chars[i]);
		end
		pkt_data.push_back(8'd0);
		if (emit) begin
			w[0] = {`OUTPKT_TYPE_CMP_RESULT, VERSION};
			w[1] = cur_pkt_id;
			w[2] = word_idx;
			w[3] = 16'(len);
			// byte 2k low and 2k+1 high
			for (int k = 0; k < 4; k++)
				w[4 + k] = {chars[2 * k + 1], chars[2 * k]};
			sum = '0;
			for (int k = 0; k < 8; k++)
				sum += w[k];
			w[8] = ~sum[15:0];
			w[9] = ~sum[31:16];
			foreach (w[k])
				exp_q.push_back(w[k]);
		end
		word_idx++;
	endtask

	// lsb first
	task automatic push_csum(input logic [31:0] v);
		for (int i = 0; i < 4; i++)
			in_q.push_back(v[8 * i +: 8]);
	endtask

	// header, header checksum, data, data checksum
	// a bad flag flips one bit of that checksum
	task automatic send_packet(input logic [7:0] version, input logic [7:0] ptype,
		input logic [23:0] len, input bit bad_hdr, input bit bad_data);
		logic [7:0] hdr [`INPKT_HEADER_LEN];
		logic [31:0] sum;
		hdr = '{version, ptype, 8'd0, 8'd0, len[7:0], len[15:8], len[23:16], 8'd0,
			cur_pkt_id[7:0], cur_pkt_id[15:8]};
		sum = '0;
		foreach (hdr[i]) begin
			in_q.push_back(hdr[i]);
			sum += hdr[i];
		end
		push_csum(~sum ^ (bad_hdr ? 32'h100 : 32'h0));
		sum = '0;
		foreach (pkt_data[i]) begin
			in_q.push_back(pkt_data[i]);
			sum += pkt_data[i];
		end
		push_csum(~sum ^ (bad_data ? 32'h100 : 32'h0));
	endtask

	task automatic random_packets(input int count);
		int n;
		repeat (count) begin
			start_packet(16'(rand_bits(16)));
			n = 1 + rand_bits(3) % 6;
			repeat (n)
				add_word(1 + rand_bits(3) % `WORD_MAX_LEN, 1'b1);
			send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b0, 1'b0);
		end
	endtask

	// ********************
	// scenario control
	// ********************
	// errors are sticky so every scenario starts from rst
	task automatic begin_scenario(input int e_rate, input int f_rate);
		@(negedge clk);
		in_q.delete();
		out_q.delete();
		exp_q.delete();
		cycles = 0;
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		empty_rate = e_rate;
		full_rate = f_rate;
	endtask

	task automatic finish_scenario(input string name, input logic [7:0] want);
		cycles = 0;
		cycle_limit = 8 * (in_q.size() + exp_q.size()) + 1000;
		// all expected words out and the expected error bits up
		do begin
			@(negedge clk);
		end while (out_q.size() < exp_q.size() || (status & want) != want
			|| (want == 8'd0 && in_q.size() != 0));
		repeat (SETTLE) @(negedge clk);
		check_val({name, " status"}, status, want);
		if (want != 8'd0)
			check_val({name, " rd_en"}, rd_en, 1'b0);
		check_val({name, " word count"}, out_q.size(), exp_q.size());
		foreach (exp_q[i])
			check_val($sformatf("%s word %0d", name, i), out_q[i], exp_q[i]);
		$display("%s: %0d words checked", name, exp_q.size());
	endtask

	// ********************
	// test sequence
	// ********************
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		din = 8'd0;
		empty = 1'b1;
		full = 1'b0;
		cycles = 0;
		cycle_limit = 1000;
		empty_rate = 0;
		full_rate = 0;

		// three words without gaps
		begin_scenario(0, 0);
		start_packet(16'h1234);
		add_word(3, 1'b1);
		add_word(`WORD_MAX_LEN, 1'b1);
		add_word(1, 1'b1);
		send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b0, 1'b0);
		finish_scenario("single packet", 8'h00);

		begin_scenario(1, 1);
		random_packets(4);
		finish_scenario("random packets", 8'h00);

		// heavy back pressure on both sides
		begin_scenario(4, 6);
		random_packets(3);
		finish_scenario("back pressure", 8'h00);

		// words after the long one are never emitted
		begin_scenario(2, 2);
		start_packet(16'h0bad);
		add_word(2, 1'b1);
		add_word(5, 1'b1);
		add_word(`WORD_MAX_LEN + 1, 1'b0);
		add_word(3, 1'b0);
		send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b0, 1'b0);
		finish_scenario("long word", 8'h20);

		begin_scenario(2, 2);
		start_packet(16'h55aa);
		add_word(4, 1'b1);
		add_word(6, 1'b1);
		send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b0, 1'b1);
		finish_scenario("data checksum", 8'h01);

		begin_scenario(2, 2);
		start_packet(16'h0f0f);
		add_word(4, 1'b0);
		send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b1, 1'b0);
		finish_scenario("header checksum", 8'h01);

		// header field errors
		begin_scenario(2, 2);
		start_packet(16'h0101);
		add_word(3, 1'b0);
		send_packet(VERSION + 8'd1, `PKT_TYPE_WORD_LIST, 24'(pkt_data.size()), 1'b0, 1'b0);
		finish_scenario("bad version", 8'h08);

		begin_scenario(2, 2);
		start_packet(16'h0202);
		add_word(3, 1'b0);
		send_packet(VERSION, 8'd3, 24'(pkt_data.size()), 1'b0, 1'b0);
		finish_scenario("bad type", 8'h04);

		begin_scenario(2, 2);
		start_packet(16'h0303);
		send_packet(VERSION, `PKT_TYPE_WORD_LIST, 24'd0, 1'b0, 1'b0);
		finish_scenario("zero length", 8'h02);

		if (dut.props.assert_fails == 0) begin
			$display("** PASS **");
			$finish;
		end else
			abort_run($sformatf("%0d assertion failures were reported",
				dut.props.assert_fails));
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/pkt_comm_pkg.sv
hdl/inpkt_header.sv
hdl/word_list.sv
hdl/outpkt.sv
hdl/pkt_comm.sv
tests/pkt_comm_properties.sv
tests/pkt_comm_tb.sv
